/* src/acc_consts.svh */
/*
  Sizes shared by the accumulator service RTL and its testbench.
  Include wherever the requester count or a datapath width is needed.
*/

`ifndef ACC_CONSTS_SVH
`define ACC_CONSTS_SVH

// Number of requesters sharing the datapath
`define NUM_SRC 4

// Accumulator and result width
`define VALUE_W 16

// Add command fields
`define IMM_W   12
`define SHIFT_W 4

// One opcode bit on top of a 16-bit body
`define CMD_W   17

`endif

/* src/acc_cmd_pkg.sv */
/*
  Command word format for the accumulator bank.
  The word is one opcode bit plus a body that is read either as a load
  value or as a shifted signed add immediate.
*/

`include "acc_consts.svh"

package acc_cmd_pkg;

  // Opcode sits in the top bit of every command word
  typedef enum logic {
    OP_LOAD = 1'b0,
    OP_ADD  = 1'b1
  } cmd_op_t;

  // Load view: replace the accumulator
  typedef struct packed {
    cmd_op_t             op;
    logic [`VALUE_W-1:0] value;
  } cmd_load_t;

  // Add view: sign-extended immediate shifted left before the add
  typedef struct packed {
    cmd_op_t                  op;
    logic [`SHIFT_W-1:0]      shift;
    logic signed [`IMM_W-1:0] imm;
  } cmd_add_t;

  // Both views are CMD_W bits and share the opcode bit
  typedef union packed {
    cmd_load_t load;
    cmd_add_t  add;
  } cmd_word_t;

endpackage

/* src/acc_flow_pkg.sv */
/*
  Requester-side types used by the arbiter, the pipe stages and the bank.
*/

`include "acc_consts.svh"

package acc_flow_pkg;

  // Index of one requester
  typedef logic [$clog2(`NUM_SRC)-1:0] src_idx_t;

  // One bit per requester, used for valid, ready and grant vectors
  typedef logic [`NUM_SRC-1:0] src_vec_t;

endpackage

/* src/flow_arb_rr.sv */
/*
  Round-robin arbiter with ready/valid on both sides.
  Grants one requester per cycle with no latency; the priority pointer
  only advances when the pop side actually takes the grant.
*/

`timescale 1ns/10ps

`include "acc_consts.svh"

module flow_arb_rr
  import acc_flow_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  src_vec_t push_valid,
  output src_vec_t push_ready,
  input  logic     pop_ready,
  output logic     pop_valid
);

  // ----------------------------------------------------------
  // Priority pointer and grant
  // ----------------------------------------------------------

  // Requester with the highest priority this cycle
  src_idx_t ptr;

  // Winner of the current arbitration
  src_idx_t win_idx;
  src_vec_t grant;
  logic     any_valid;

  // Scan from the pointer and wrap around
  always_comb begin
    win_idx   = ptr;
    any_valid = 1'b0;
    for (int k = 0; k < `NUM_SRC; k++) begin
      // First valid requester at or after ptr wins
      if (!any_valid && push_valid[(int'(ptr) + k) % `NUM_SRC]) begin
        any_valid = 1'b1;
        win_idx   = src_idx_t'((int'(ptr) + k) % `NUM_SRC);
      end
    end
  end

  // One-hot grant, all zero when nobody requests
  always_comb begin
    grant          = '0;
    grant[win_idx] = any_valid;
  end

  // ----------------------------------------------------------
  // Flow control
  // ----------------------------------------------------------

  assign pop_valid = any_valid;

  // Only the winner sees ready, and only if the pop side can take it
  assign push_ready = pop_ready ? grant : '0;

  // Move priority to one past the winner on a completed pop
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (pop_valid && pop_ready) begin
      ptr <= src_idx_t'((int'(win_idx) + 1) % `NUM_SRC);
    end
  end

endmodule

/* src/flow_mux_rr.sv */
/*
  Flow-controlled multiplexer with round-robin arbitration.
  Pops the granted requester's command in the same cycle it is pushed and
  passes the granted index along so later stages know the owner.
*/

`timescale 1ns/10ps

`include "acc_consts.svh"

module flow_mux_rr
  import acc_cmd_pkg::*;
  import acc_flow_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  src_vec_t                   push_valid,
  output src_vec_t                   push_ready,
  input  cmd_word_t [`NUM_SRC-1:0]   push_data,
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output cmd_word_t                  pop_data,
  output src_idx_t                   pop_src
);

  // Arbitration and handshakes
  flow_arb_rr arb0 (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid)
  );

  // ----------------------------------------------------------
  // Grant to index
  // ----------------------------------------------------------

  src_idx_t grant_idx;

  // At most one bit of push_valid & push_ready is set
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < `NUM_SRC; i++) begin
      if (push_valid[i] && push_ready[i]) begin
        grant_idx = src_idx_t'(i);
      end
    end
  end

  // Data select and owner tag
  assign pop_data = push_data[grant_idx];
  assign pop_src  = grant_idx;

endmodule

/* src/flow_reg_fwd.sv */
/*
  One-entry forward pipe register on a ready/valid link.
  Cuts the combinational valid/data path and still moves one item per
  cycle, since it accepts whenever it is empty or being drained.
*/

`timescale 1ns/10ps

module flow_reg_fwd
  import acc_cmd_pkg::*;
  import acc_flow_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      push_valid,
  output logic      push_ready,
  input  cmd_word_t push_cmd,
  input  src_idx_t  push_src,
  output logic      pop_valid,
  input  logic      pop_ready,
  output cmd_word_t pop_cmd,
  output src_idx_t  pop_src
);

  logic full;

  // Room when empty or when the held item leaves this cycle
  assign push_ready = !full || pop_ready;
  assign pop_valid  = full;

  // Occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (push_valid && push_ready) begin
      full <= 1'b1;
    end else if (pop_ready) begin
      full <= 1'b0;
    end
  end

  // Payload follows every accepted push
  always_ff @(posedge clk) begin
    if (push_valid && push_ready) begin
      pop_cmd <= push_cmd;
      pop_src <= push_src;
    end
  end

endmodule

/* src/acc_bank.sv */
/*
  Per-requester accumulators and command execution.
  An accepted command updates its owner's accumulator; the new value goes
  out one cycle later with the owner index and is held until taken.
*/

`timescale 1ns/10ps

`include "acc_consts.svh"

module acc_bank
  import acc_cmd_pkg::*;
  import acc_flow_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  cmd_word_t           cmd,
  input  src_idx_t            cmd_src,
  output logic                result_valid,
  input  logic                result_ready,
  output src_idx_t            result_src,
  output logic [`VALUE_W-1:0] result_value
);

  // ----------------------------------------------------------
  // Command execution
  // ----------------------------------------------------------

  logic [`VALUE_W-1:0] acc [`NUM_SRC];

  logic [`VALUE_W-1:0] imm_ext;
  logic [`VALUE_W-1:0] add_term;
  logic [`VALUE_W-1:0] next_value;
  logic                accept;

  // New work only when the result slot is free or draining
  assign cmd_ready = !result_valid || result_ready;
  assign accept    = cmd_valid && cmd_ready;

  // Sign-extend the immediate, then shift inside VALUE_W bits
  assign imm_ext  = {{(`VALUE_W - `IMM_W){cmd.add.imm[`IMM_W-1]}}, cmd.add.imm};
  assign add_term = imm_ext << cmd.add.shift;

  // Opcode bit is shared, so either view decides. Sum wraps mod 2^16
  assign next_value = (cmd.load.op == OP_ADD) ? acc[cmd_src] + add_term
                                              : cmd.load.value;

  // Accumulators start at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_SRC; i++) begin
        acc[i] <= '0;
      end
    end else if (accept) begin
      acc[cmd_src] <= next_value;
    end
  end

  // ----------------------------------------------------------
  // Result register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else if (accept) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  // Held stable while the consumer stalls
  always_ff @(posedge clk) begin
    if (accept) begin
      result_value <= next_value;
      result_src   <= cmd_src;
    end
  end

endmodule

/* src/acc_service_top.sv */
/*
  Shared accumulator service.
  Round-robin mux, forward pipe register and accumulator bank in a row;
  a command pushed at one edge yields its result two edges later.
*/

`timescale 1ns/10ps

`include "acc_consts.svh"

module acc_service_top
  import acc_cmd_pkg::*;
  import acc_flow_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  src_vec_t                 push_valid,
  output src_vec_t                 push_ready,
  input  cmd_word_t [`NUM_SRC-1:0] push_data,
  output logic                     result_valid,
  input  logic                     result_ready,
  output src_idx_t                 result_src,
  output logic [`VALUE_W-1:0]      result_value
);

  // Mux to register link
  logic      mux_valid;
  logic      mux_ready;
  cmd_word_t mux_cmd;
  src_idx_t  mux_src;

  // Register to bank link
  logic      reg_valid;
  logic      reg_ready;
  cmd_word_t reg_cmd;
  src_idx_t  reg_src;

  // ----------------------------------------------------------
  // Stage 0, arbitration
  // ----------------------------------------------------------
  flow_mux_rr mux0 (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_ready  (mux_ready),
    .pop_valid  (mux_valid),
    .pop_data   (mux_cmd),
    .pop_src    (mux_src)
  );

  // Stage 1, pipe register
  flow_reg_fwd reg0 (
    .clk        (clk),
    .rst        (rst),
    .push_valid (mux_valid),
    .push_ready (mux_ready),
    .push_cmd   (mux_cmd),
    .push_src   (mux_src),
    .pop_valid  (reg_valid),
    .pop_ready  (reg_ready),
    .pop_cmd    (reg_cmd),
    .pop_src    (reg_src)
  );

  // Stage 2, execute and return
  acc_bank bank0 (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (reg_valid),
    .cmd_ready    (reg_ready),
    .cmd          (reg_cmd),
    .cmd_src      (reg_src),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_src   (result_src),
    .result_value (result_value)
  );

endmodule

/* verification/acc_service_assertions.sv */
/*
  Flow-control assertions for the accumulator service, bound into the top.
  Covers the grant vector, stall stability on both outer links and the
  valid outputs in the cycle after reset.
*/

`timescale 1ns/10ps

`include "acc_consts.svh"

module acc_service_assertions
  import acc_cmd_pkg::*;
  import acc_flow_pkg::*;
(
  input logic                     clk,
  input logic                     rst,
  input src_vec_t                 push_valid,
  input src_vec_t                 push_ready,
  input cmd_word_t [`NUM_SRC-1:0] push_data,
  input logic                     reg_valid,
  input logic                     result_valid,
  input logic                     result_ready,
  input src_idx_t                 result_src,
  input logic [`VALUE_W-1:0]      result_value
);

  // Number of assertion failures so far
  int fail_count = 0;

  // ----------------------------------------------------------
  // Push side
  // ----------------------------------------------------------

  // At most one requester granted per cycle
  assert property (@(posedge clk) disable iff (rst) $onehot0(push_ready))
    else begin
      $error("push_ready has more than one bit set");
      fail_count++;
    end

  // A stalled requester keeps valid and data
  for (genvar i = 0; i < `NUM_SRC; i++) begin : g_push
    assert property (@(posedge clk) disable iff (rst)
      push_valid[i] && !push_ready[i] |=> push_valid[i] && $stable(push_data[i]))
      else begin
        $error("requester %0d dropped valid or changed data while stalled", i);
        fail_count++;
      end
  end

  // ----------------------------------------------------------
  // Result side and reset
  // ----------------------------------------------------------

  // Held result stays put until taken
  assert property (@(posedge clk) disable iff (rst)
    result_valid && !result_ready |=>
      result_valid && $stable(result_src) && $stable(result_value))
    else begin
      $error("result changed or vanished while stalled");
      fail_count++;
    end

  // Pipe register and bank come out of reset empty
  assert property (@(posedge clk) rst |=> !result_valid && !reg_valid)
    else begin
      $error("valid output high in the cycle after reset");
      fail_count++;
    end

endmodule

bind acc_service_top acc_service_assertions asrt0 (.*);

/* verification/acc_service_tb.sv */
/*
  Testbench for the shared accumulator service.
  Random load and add traffic from a fixed seed is checked against a
  per-requester accumulator model. Compile with the file list, top acc_service_tb.
*/

`timescale 1ns/10ps

`include "acc_consts.svh"

module acc_service_tb
  import acc_cmd_pkg::*;
  import acc_flow_pkg::*;
();

  // Test lengths in cycles
  // Back-pressure test runs at about half rate
  localparam int LEN_TOTAL   = 8 + 4 + 40 + 48 + 64 + 2 * 64 + 4;
  localparam int CYCLE_LIMIT = 2 * LEN_TOTAL + 100;
  localparam int DEPTH       = 512;

  logic                     clk;
  logic                     rst;
  src_vec_t                 push_valid;
  src_vec_t                 push_ready;
  cmd_word_t [`NUM_SRC-1:0] push_data;
  logic                     result_valid;
  logic                     result_ready;
  src_idx_t                 result_src;
  logic [`VALUE_W-1:0]      result_value;

  // Stimulus and expected results in one FIFO per requester
  cmd_word_t           stim_mem [`NUM_SRC][DEPTH];
  logic [`VALUE_W-1:0] exp_mem [`NUM_SRC][DEPTH];
  int                  stim_head [`NUM_SRC];
  int                  stim_tail [`NUM_SRC];
  int                  exp_head [`NUM_SRC];
  int                  exp_tail [`NUM_SRC];
  logic [`VALUE_W-1:0] model_acc [`NUM_SRC];

  integer   seed;
  src_vec_t took;
  src_idx_t prev_src;
  bit       bp_mode;
  bit       rr_mode;
  bit       have_prev;
  int       cycles;
  int       errors;
  int       pushes;
  int       results;
  int       checks;
  int       base_push;
  int       base_res;
  int       base_err;

  acc_service_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_data    (push_data),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_src   (result_src),
    .result_value (result_value)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Hard stop if the tests stall
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run passed %0d cycles before the tests finished", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  // Load replaces and add uses sign-extended imm times 2^shift mod 2^16
  function automatic logic [`VALUE_W-1:0] model_exec(logic [`VALUE_W-1:0] cur,
                                                     cmd_word_t c);
    int term;
    int sum;
    if (c.add.op == OP_LOAD) begin
      return c.load.value;
    end
    term = int'($signed(c.add.imm)) * (1 << c.add.shift);
    sum  = int'(cur) + term;
    return sum[`VALUE_W-1:0];
  endfunction

  // Kind 1 forces an add and any other kind keeps the random opcode
  function automatic cmd_word_t rand_cmd(input int kind);
    logic [31:0] r;
    cmd_word_t   c;
    r = $random(seed);
    c = r[`CMD_W-1:0];
    if (kind == 1) c.add.op = OP_ADD;
    return c;
  endfunction

  task automatic queue_cmd(input int src, input cmd_word_t c);
    stim_mem[src][stim_tail[src]] = c;
    stim_tail[src]++;
  endtask

  function automatic bit pipeline_busy();
    bit b;
    b = result_valid || (push_valid != '0);
    for (int i = 0; i < `NUM_SRC; i++) begin
      if (stim_head[i] != stim_tail[i] || exp_head[i] != exp_tail[i]) b = 1'b1;
    end
    return b;
  endfunction

  task automatic check_result();
    int s;
    s = int'(result_src);
    results++;
    // Round-robin step under full load
    if (rr_mode && have_prev && result_src != src_idx_t'(prev_src + 1)) begin
      $display("FAILED at %0t: requester %0d served after %0d", $time, s, prev_src);
      errors++;
    end
    prev_src  = result_src;
    have_prev = 1'b1;
    if (exp_head[s] == exp_tail[s]) begin
      $display("Error at %0t: result for requester %0d with nothing outstanding", $time, s);
      errors++;
    end else begin
      checks++;
      if (result_value != exp_mem[s][exp_head[s]]) begin
        $display("FAILED at %0t: requester %0d result %h, expected %h", $time, s,
                 result_value, exp_mem[s][exp_head[s]]);
        errors++;
      end
      exp_head[s]++;
    end
  endtask

  // ----------------------------------------------------------
  // Monitor at falling edge and driver just after rising edge
  // ----------------------------------------------------------

  always @(negedge clk) begin
    took = push_valid & push_ready;
    for (int i = 0; i < `NUM_SRC; i++) begin
      if (took[i]) begin
        model_acc[i] = model_exec(model_acc[i], push_data[i]);
        exp_mem[i][exp_tail[i]] = model_acc[i];
        exp_tail[i]++;
        pushes++;
      end
    end
    if (result_valid && result_ready) check_result();
  end

  always @(posedge clk) begin
    #1;
    result_ready = bp_mode ? 1'($random(seed)) : 1'b1;
    for (int i = 0; i < `NUM_SRC; i++) begin
      // Hold until accepted and then present the next command
      if (took[i]) push_valid[i] = 1'b0;
      if (!push_valid[i] && stim_head[i] != stim_tail[i]) begin
        push_data[i]  = stim_mem[i][stim_head[i]];
        stim_head[i]++;
        push_valid[i] = 1'b1;
      end
    end
  end

  task automatic end_test(input string name);
    do @(negedge clk); while (pipeline_busy());
    if (pushes - base_push != results - base_res) begin
      $display("FAILED at %0t: %0d results for %0d accepted commands", $time,
               results - base_res, pushes - base_push);
      errors++;
    end
    $display("test %s: done, %0d commands, %0d errors", name, pushes - base_push,
             errors - base_err);
    base_push = pushes;
    base_res  = results;
    base_err  = errors;
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    logic [31:0] r;
    int          lat;
    seed         = 78;
    rst          = 1'b1;
    push_valid   = '0;
    push_data    = '0;
    result_ready = 1'b1;
    took         = '0;
    for (int i = 0; i < `NUM_SRC; i++) begin
      stim_head[i] = 0;
      stim_tail[i] = 0;
      exp_head[i]  = 0;
      exp_tail[i]  = 0;
      model_acc[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    if (result_valid || push_ready != '0) begin
      $display("FAILED at %0t: valid or ready high right after reset", $time);
      errors++;
    end

    // Accumulators start at zero so each add returns its own term
    for (int i = 0; i < `NUM_SRC; i++) queue_cmd(i, rand_cmd(1));
    end_test("1 reset state");

    for (int n = 0; n < 40; n++) queue_cmd(1, rand_cmd(2));
    end_test("2 load and add decoding");

    // All four busy so grants must rotate
    have_prev = 1'b0;
    rr_mode   = 1'b1;
    for (int n = 0; n < 12; n++) begin
      for (int i = 0; i < `NUM_SRC; i++) queue_cmd(i, rand_cmd(2));
    end
    end_test("3 round-robin order");
    rr_mode = 1'b0;

    for (int n = 0; n < 64; n++) begin
      r = $random(seed);
      queue_cmd(int'(r[1:0]), rand_cmd(2));
    end
    end_test("4 independence");

    bp_mode = 1'b1;
    for (int n = 0; n < 64; n++) begin
      r = $random(seed);
      queue_cmd(int'(r[1:0]), rand_cmd(2));
    end
    end_test("5 back-pressure");
    bp_mode = 1'b0;

    // Single push into an idle pipe with ready held high
    @(negedge clk);
    queue_cmd(2, rand_cmd(2));
    do @(negedge clk); while (!(push_valid[2] && push_ready[2]));
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!result_valid && lat < 10);
    if (lat != 2) begin
      $display("FAILED at %0t: result_valid %0d edges after push, expected 2", $time, lat);
      errors++;
    end
    end_test("6 latency");

    $display("summary: %0d commands, %0d results checked, %0d errors, %0d assertion failures",
             pushes, checks, errors, dut0.asrt0.fail_count);
    if (errors == 0 && dut0.asrt0.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* acc_service_top.f */
+incdir+src
src/acc_cmd_pkg.sv
src/acc_flow_pkg.sv
src/flow_arb_rr.sv
src/flow_mux_rr.sv
src/flow_reg_fwd.sv
src/acc_bank.sv
src/acc_service_top.sv
verification/acc_service_assertions.sv
verification/acc_service_tb.sv
